//--- verilog.f
logic/gcu_bus_pkg.sv
logic/gcu_vram_pkg.sv
logic/gcu_ram_pointer.sv
logic/gcu_scroll_regs.sv
logic/gcu_vram.sv
logic/gcu_video_status.sv
logic/gcu_bus_sequencer.sv
logic/gcu_top.sv
tests/gcu_checker.sv
tests/gcu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the gcu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module gcu_tb -f verilog.f -o gcu_sim

./obj_dir/gcu_sim | tee sim.log

# the run passes only if the testbench printed the pass line
grep -q "^ALL TESTS PASSED$" sim.log
echo "simulation passed"

//--- tests/gcu_tb.sv
// ------------------------------------------------------------
// testbench for the graphics control unit bus side:
// clock and reset, LFSR, value check and directed tests
// for scroll registers, RAM, layer copies, sync and vint
// ------------------------------------------------------------
`default_nettype none

module gcu_tb;

    localparam int ACK_TIMEOUT = 16;

    // strobe numbers for the bus task
    localparam int OP_SEL  = 0;
    localparam int OP_WREG = 1;
    localparam int OP_SETP = 2;
    localparam int OP_WRAM = 3;
    localparam int OP_RDH  = 4;
    localparam int OP_RDL  = 5;

    logic        CLK96;
    logic        RESET96;
    logic        select_reg;
    logic        write_reg;
    logic        set_ram_ptr;
    logic        write_ram;
    logic        read_ram_h;
    logic        read_ram_l;
    logic [15:0] din;
    logic        ack;
    logic [15:0] dout;
    logic        vint;
    logic [8:0]  h;
    logic [8:0]  v;
    logic [8:0]  hs_start;
    logic [8:0]  hs_end;
    logic [8:0]  vs_start;
    logic [8:0]  vs_end;
    logic        hsync;
    logic        vsync;
    logic        fblank;
    logic [12:0] bg_scroll_x;
    logic [12:0] bg_scroll_y;
    logic [12:0] fg_scroll_x;
    logic [12:0] fg_scroll_y;
    logic [12:0] txt_scroll_x;
    logic [12:0] txt_scroll_y;
    logic [12:0] spr_scroll_x;
    logic [12:0] spr_scroll_y;
    logic [10:0] scr0_addr;
    logic [10:0] scr1_addr;
    logic [10:0] scr2_addr;
    logic [10:0] spr_addr;
    logic [15:0] scr0_dout;
    logic [15:0] scr1_dout;
    logic [15:0] scr2_dout;
    logic [15:0] spr_dout;

    // reference state kept by the testbench
    logic [15:0] ram_model [8192];
    logic [15:0] layer_model [4][2048];
    bit          layer_known [4][2048];
    logic [12:0] ptr_model;
    logic [31:0] lfsr_state;
    int          errors;

    string scroll_name [8] = '{"bg_scroll_x", "bg_scroll_y", "fg_scroll_x", "fg_scroll_y",
                               "txt_scroll_x", "txt_scroll_y", "spr_scroll_x", "spr_scroll_y"};

    gcu_top dut0 (.*);

    always begin
        #4 CLK96 = ~CLK96;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [12:0] scroll_out(input int i);
        case (i)
            0:       return bg_scroll_x;
            1:       return bg_scroll_y;
            2:       return fg_scroll_x;
            3:       return fg_scroll_y;
            4:       return txt_scroll_x;
            5:       return txt_scroll_y;
            6:       return spr_scroll_x;
            default: return spr_scroll_y;
        endcase
    endfunction

    task automatic set_strobe(input int which, input logic val);
        case (which)
            OP_SEL:  select_reg = val;
            OP_WREG: write_reg = val;
            OP_SETP: set_ram_ptr = val;
            OP_WRAM: write_ram = val;
            OP_RDH:  read_ram_h = val;
            default: read_ram_l = val;
        endcase
    endtask

    // called on a falling edge, returns on one; counts cycles with ack low
    task automatic bus_cycle(input int which, input logic [15:0] data, output int low_cycles);
        low_cycles = 0;
        din = data;
        set_strobe(which, 1'b1);
        @(negedge CLK96);
        while (!ack) begin
            low_cycles++;
            if (low_cycles > ACK_TIMEOUT) begin
                $display("timeout: ack stayed low for %0d cycles at %0t", low_cycles, $time);
                $display("SOME TESTS FAILED");
                $finish;
            end
            @(negedge CLK96);
        end
        set_strobe(which, 1'b0);
        // one idle cycle so the next op is seen as new
        @(negedge CLK96);
    endtask

    task automatic set_ptr(input logic [12:0] addr);
        logic [31:0] r;
        int          low;
        take_bits(3, r);
        // bits above the RAM width are ignored
        bus_cycle(OP_SETP, {r[2:0], addr}, low);
        check("set_ptr ack low cycles", low, 0);
        ptr_model = addr;
    endtask

    task automatic ram_write(input logic [15:0] data);
        int low;
        int rg;
        bus_cycle(OP_WRAM, data, low);
        check("write ack low cycles", low, 1);
        ram_model[ptr_model] = data;
        if (ptr_model < 13'h1C00) begin
            rg = int'(ptr_model[12:11]);
            layer_model[rg][ptr_model[10:0]] = data;
            layer_known[rg][ptr_model[10:0]] = 1'b1;
        end
        ptr_model = ptr_model + 13'd1;
    endtask

    task automatic ram_read(input int which, input logic [12:0] addr);
        int low;
        bus_cycle(which, 16'h0000, low);
        check("read ack low cycles", low, 2);
        check("dout", dout, ram_model[addr]);
    endtask

    task automatic check_layers(input logic [10:0] idx);
        scr0_addr = idx;
        scr1_addr = idx;
        scr2_addr = idx;
        spr_addr = idx;
        @(negedge CLK96);
        if (layer_known[0][idx]) check("scr0_dout", scr0_dout, layer_model[0][idx]);
        if (layer_known[1][idx]) check("scr1_dout", scr1_dout, layer_model[1][idx]);
        if (layer_known[2][idx]) check("scr2_dout", scr2_dout, layer_model[2][idx]);
        if (layer_known[3][idx]) check("spr_dout", spr_dout, layer_model[3][idx]);
    endtask

    task automatic test_reset_state;
        check("ack", ack, 1'b1);
        for (int i = 0; i < 8; i++) begin
            check(scroll_name[i], scroll_out(i), 13'h0000);
        end
        check("vint", vint, 1'b0);
    endtask

    task automatic test_scroll_regs;
        logic [12:0] exp [8];
        logic [31:0] r;
        logic [7:0]  num;
        int          low;
        for (int i = 0; i < 8; i++) begin
            exp[i] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            take_bits(9, r);
            // bit 7 picks the alias, the upper din byte is noise
            num = {r[8], 4'h0, 3'(i)};
            bus_cycle(OP_SEL, {r[7:0], num}, low);
            check("select ack low cycles", low, 0);
            take_bits(16, r);
            bus_cycle(OP_WREG, r[15:0], low);
            exp[i] = r[12:0];
            for (int j = 0; j < 8; j++) begin
                check(scroll_name[j], scroll_out(j), exp[j]);
            end
        end
        // 0x0a has bit 3 set, so the write goes nowhere
        bus_cycle(OP_SEL, 16'h000A, low);
        take_bits(16, r);
        bus_cycle(OP_WREG, r[15:0], low);
        for (int j = 0; j < 8; j++) begin
            check(scroll_name[j], scroll_out(j), exp[j]);
        end
    endtask

    task automatic test_ram_rw;
        logic [31:0] r;
        logic [12:0] base;
        take_bits(13, r);
        base = r[12:0];
        set_ptr(base);
        for (int k = 0; k < 9; k++) begin
            take_bits(16, r);
            ram_write(r[15:0]);
        end
        for (int k = 0; k < 8; k++) begin
            set_ptr(base + 13'(k));
            ram_read(OP_RDH, base + 13'(k));
            ram_read(OP_RDL, base + 13'(k + 1));
        end
        // reads must leave the pointer alone
        ram_read(OP_RDH, base + 13'd7);
    endtask

    task automatic test_regions;
        logic [31:0] r;
        logic [10:0] off;
        logic [12:0] addr;
        logic [15:0] past_data;
        for (int rg = 0; rg < 4; rg++) begin
            take_bits(11, r);
            off = r[10:0];
            // sprite window is 1K words
            if (rg == 3) off[10] = 1'b0;
            addr = 13'(rg * 32'h800) + 13'(off);
            set_ptr(addr);
            take_bits(16, r);
            ram_write(r[15:0]);
            check_layers(off);
        end
        // same low bits in the three tile copies, then a write past the sprite window
        take_bits(10, r);
        off = {1'b1, r[9:0]};
        for (int rg = 0; rg < 3; rg++) begin
            set_ptr(13'(rg * 32'h800) + 13'(off));
            take_bits(16, r);
            ram_write(r[15:0]);
        end
        addr = 13'h1800 + 13'(off);
        set_ptr(addr);
        take_bits(16, r);
        past_data = r[15:0];
        ram_write(past_data);
        check_layers(off);
        // sprite copy index beyond its 1K window is never written
        if (spr_dout === past_data) begin
            errors++;
            $display("FAILED at %0t: spr_dout = %h, expected any value but %h",
                     $time, spr_dout, past_data);
        end
        set_ptr(addr);
        ram_read(OP_RDH, addr);
    endtask

    task automatic test_sync_vint;
        logic [31:0] r;
        logic [7:0]  sel_vals [8];
        logic [7:0]  masked;
        logic        exp_hs;
        logic        exp_vs;
        int          low;
        sel_vals = '{8'h0F, 8'h8F, 8'h0E, 8'h1F, 8'hFF, 8'h0D, 8'h8E, 8'h07};
        take_bits(7, r);
        hs_start = 9'(16 + r[6:0]);
        take_bits(5, r);
        hs_end = hs_start + 9'(20 + r[4:0]);
        take_bits(6, r);
        vs_start = 9'(100 + r[5:0]);
        take_bits(3, r);
        vs_end = vs_start + 9'(4 + r[2:0]);
        for (int hv = hs_start - 2; hv <= hs_end + 2; hv++) begin
            for (int vv = vs_start - 2; vv <= vs_end + 2; vv++) begin
                @(negedge CLK96);
                h = 9'(hv);
                v = 9'(vv);
                @(posedge CLK96);
                exp_hs = !(hv > hs_start && hv < hs_end);
                exp_vs = !(vv >= vs_start && vv <= vs_end);
                check("hsync", hsync, exp_hs);
                check("vsync", vsync, exp_vs);
                check("fblank", fblank, exp_hs && exp_vs);
            end
        end
        @(negedge CLK96);
        v = 9'h0E6;
        @(negedge CLK96);
        check("vint at line 0xe6", vint, 1'b0);
        v = 9'h0E5;
        @(negedge CLK96);
        check("vint at line 0xe5", vint, 1'b1);
        v = 9'h000;
        for (int i = 0; i < 8; i++) begin
            bus_cycle(OP_SEL, {8'h00, sel_vals[i]}, low);
            masked = sel_vals[i] & 8'h8F;
            check("vint", vint, !(masked == 8'h0F || masked == 8'h8F || masked == 8'h0E));
        end
    endtask

    initial begin
        errors = 0;
        lfsr_state = 32'ha913_671d;
        CLK96 = 1'b0;
        RESET96 = 1'b1;
        select_reg = 1'b0;
        write_reg = 1'b0;
        set_ram_ptr = 1'b0;
        write_ram = 1'b0;
        read_ram_h = 1'b0;
        read_ram_l = 1'b0;
        din = '0;
        h = '0;
        v = '0;
        hs_start = '0;
        hs_end = '0;
        vs_start = '0;
        vs_end = '0;
        scr0_addr = '0;
        scr1_addr = '0;
        scr2_addr = '0;
        spr_addr = '0;
        ptr_model = '0;
        repeat (16) @(negedge CLK96);
        test_reset_state();
        RESET96 = 1'b0;
        @(negedge CLK96);
        check("vint after reset", vint, 1'b1);
        test_scroll_regs();
        test_ram_rw();
        test_regions();
        test_sync_vint();
        $display("check errors: %0d, assertion failures: %0d",
                 errors, dut0.u_seq.bus_chk.fails);
        if (errors == 0 && dut0.u_seq.bus_chk.fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/gcu_checker.sv
// ------------------------------------------------------------
// assertions on the bus sequencer: ram_we width and the
// number of cycles ack stays low for writes and reads
// ------------------------------------------------------------
`default_nettype none

module gcu_checker (
    input wire logic CLK96,
    input wire logic RESET96,
    input wire logic ack,
    input wire logic ram_we
);

    int fails = 0;

    // a RAM write strobe covers exactly one edge
    we_one_cycle: assert property (@(posedge CLK96) disable iff (RESET96)
        ram_we |=> !ram_we)
        else begin
            $error("ram_we stayed high for more than one cycle");
            fails = fails + 1;
        end

    // write op drops ack for one cycle
    write_ack_low: assert property (@(posedge CLK96) disable iff (RESET96)
        $fell(ack) && ram_we |=> ack)
        else begin
            $error("ack not back high one cycle after a RAM write started");
            fails = fails + 1;
        end

    // read ops drop ack for two cycles
    read_ack_low: assert property (@(posedge CLK96) disable iff (RESET96)
        $fell(ack) && !ram_we |=> !ack ##1 ack)
        else begin
            $error("ack not low for exactly two cycles on a RAM read");
            fails = fails + 1;
        end

endmodule

bind gcu_bus_sequencer gcu_checker bus_chk (
    .CLK96(CLK96),
    .RESET96(RESET96),
    .ack(ack),
    .ram_we(ram_we)
);

`default_nettype wire

//--- logic/gcu_top.sv
// ------------------------------------------------------------
// graphics control unit CPU-bus side: bus sequencer, RAM
// pointer, scroll registers, video RAM and video status
// ------------------------------------------------------------
`default_nettype none

module gcu_top #(
    parameter int AW       = gcu_vram_pkg::VRAM_AW,
    parameter int LAYER_AW = gcu_vram_pkg::LAYER_AW
) (
    input  wire logic                             CLK96,
    input  wire logic                             RESET96,
    input  wire logic                             select_reg,
    input  wire logic                             write_reg,
    input  wire logic                             set_ram_ptr,
    input  wire logic                             write_ram,
    input  wire logic                             read_ram_h,
    input  wire logic                             read_ram_l,
    input  wire logic [gcu_bus_pkg::DATA_W-1:0]   din,
    output logic                                  ack,
    output logic      [gcu_bus_pkg::DATA_W-1:0]   dout,
    output logic                                  vint,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]  h,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]  v,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]  hs_start,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]  hs_end,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]  vs_start,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]  vs_end,
    output logic                                  hsync,
    output logic                                  vsync,
    output logic                                  fblank,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0] bg_scroll_x,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0] bg_scroll_y,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0] fg_scroll_x,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0] fg_scroll_y,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0] txt_scroll_x,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0] txt_scroll_y,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0] spr_scroll_x,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0] spr_scroll_y,
    input  wire logic [LAYER_AW-1:0]              scr0_addr,
    input  wire logic [LAYER_AW-1:0]              scr1_addr,
    input  wire logic [LAYER_AW-1:0]              scr2_addr,
    input  wire logic [LAYER_AW-1:0]              spr_addr,
    output logic      [gcu_bus_pkg::DATA_W-1:0]   scr0_dout,
    output logic      [gcu_bus_pkg::DATA_W-1:0]   scr1_dout,
    output logic      [gcu_bus_pkg::DATA_W-1:0]   scr2_dout,
    output logic      [gcu_bus_pkg::DATA_W-1:0]   spr_dout
);

    logic                              reg_select;
    logic                              reg_write;
    logic                              ptr_load;
    logic                              ptr_inc;
    logic [AW-1:0]                     ptr;
    logic [AW-1:0]                     ram_addr;
    logic [gcu_bus_pkg::DATA_W-1:0]    ram_wdata;
    logic [gcu_bus_pkg::DATA_W-1:0]    ram_rdata;
    logic                              ram_we;
    logic [gcu_bus_pkg::REG_NUM_W-1:0] sel_reg;

    gcu_bus_sequencer #(.AW(AW)) u_seq (
        .CLK96(CLK96), .RESET96(RESET96),
        .select_reg(select_reg), .write_reg(write_reg), .set_ram_ptr(set_ram_ptr),
        .write_ram(write_ram), .read_ram_h(read_ram_h), .read_ram_l(read_ram_l),
        .din(din), .ptr(ptr), .ram_rdata(ram_rdata),
        .ack(ack), .dout(dout), .reg_select(reg_select), .reg_write(reg_write),
        .ptr_load(ptr_load), .ptr_inc(ptr_inc),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we)
    );

    gcu_ram_pointer #(.AW(AW)) u_ptr (
        .CLK96(CLK96), .RESET96(RESET96),
        .ptr_load(ptr_load), .ptr_inc(ptr_inc), .din(din), .ptr(ptr)
    );

    gcu_scroll_regs u_regs (
        .CLK96(CLK96), .RESET96(RESET96),
        .reg_select(reg_select), .reg_write(reg_write), .din(din), .sel_reg(sel_reg),
        .bg_scroll_x(bg_scroll_x), .bg_scroll_y(bg_scroll_y),
        .fg_scroll_x(fg_scroll_x), .fg_scroll_y(fg_scroll_y),
        .txt_scroll_x(txt_scroll_x), .txt_scroll_y(txt_scroll_y),
        .spr_scroll_x(spr_scroll_x), .spr_scroll_y(spr_scroll_y)
    );

    gcu_vram #(.AW(AW), .LAYER_AW(LAYER_AW)) u_vram (
        .CLK96(CLK96),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
        .scr0_addr(scr0_addr), .scr1_addr(scr1_addr),
        .scr2_addr(scr2_addr), .spr_addr(spr_addr),
        .ram_rdata(ram_rdata),
        .scr0_dout(scr0_dout), .scr1_dout(scr1_dout),
        .scr2_dout(scr2_dout), .spr_dout(spr_dout)
    );

    gcu_video_status u_status (
        .RESET96(RESET96), .h(h), .v(v),
        .hs_start(hs_start), .hs_end(hs_end), .vs_start(vs_start), .vs_end(vs_end),
        .sel_reg(sel_reg),
        .hsync(hsync), .vsync(vsync), .fblank(fblank), .vint(vint)
    );

endmodule

`default_nettype wire

//--- logic/gcu_bus_sequencer.sv
// ------------------------------------------------------------
// CPU bus sequencer: decodes the op strobes, runs each op,
// drives ack, dout and the main video RAM port
// ------------------------------------------------------------
`default_nettype none

module gcu_bus_sequencer #(
    parameter int AW = gcu_vram_pkg::VRAM_AW
) (
    input  wire logic                            CLK96,
    input  wire logic                            RESET96,
    input  wire logic                            select_reg,
    input  wire logic                            write_reg,
    input  wire logic                            set_ram_ptr,
    input  wire logic                            write_ram,
    input  wire logic                            read_ram_h,
    input  wire logic                            read_ram_l,
    input  wire logic [gcu_bus_pkg::DATA_W-1:0]  din,
    input  wire logic [AW-1:0]                   ptr,
    input  wire logic [gcu_bus_pkg::DATA_W-1:0]  ram_rdata,
    output logic                                 ack,
    output logic      [gcu_bus_pkg::DATA_W-1:0]  dout,
    output logic                                 reg_select,
    output logic                                 reg_write,
    output logic                                 ptr_load,
    output logic                                 ptr_inc,
    output logic      [AW-1:0]                   ram_addr,
    output logic      [gcu_bus_pkg::DATA_W-1:0]  ram_wdata,
    output logic                                 ram_we
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE,
        ST_WRITE_DONE,
        ST_READ_ADDR,
        ST_READ_WAIT,
        ST_READ_DONE
    } state_t;

    gcu_bus_pkg::bus_op_t op;
    gcu_bus_pkg::bus_op_t last_op;
    state_t               state;
    logic                 new_op;
    logic                 start_read;

    // strobe priority follows the enum order
    always_comb begin
        if (select_reg) begin
            op = gcu_bus_pkg::OP_SELECT;
        end else if (write_reg) begin
            op = gcu_bus_pkg::OP_WRITE_REG;
        end else if (set_ram_ptr) begin
            op = gcu_bus_pkg::OP_SET_PTR;
        end else if (write_ram) begin
            op = gcu_bus_pkg::OP_WRITE_RAM;
        end else if (read_ram_h) begin
            op = gcu_bus_pkg::OP_READ_H;
        end else if (read_ram_l) begin
            op = gcu_bus_pkg::OP_READ_L;
        end else begin
            op = gcu_bus_pkg::OP_NONE;
        end
    end

    // a held strobe is one op, so only a change starts work
    assign new_op     = (op != last_op);
    assign start_read = new_op && (op == gcu_bus_pkg::OP_READ_H
                                   || op == gcu_bus_pkg::OP_READ_L);

    assign reg_select = new_op && (op == gcu_bus_pkg::OP_SELECT);
    assign reg_write  = new_op && (op == gcu_bus_pkg::OP_WRITE_REG);
    assign ptr_load   = new_op && (op == gcu_bus_pkg::OP_SET_PTR);

    // write lands and pointer steps on the same edge
    assign ram_we  = (state == ST_WRITE);
    assign ptr_inc = (state == ST_WRITE);
    assign ack     = !(state inside {ST_WRITE, ST_READ_ADDR, ST_READ_WAIT});

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state   <= ST_IDLE;
            last_op <= gcu_bus_pkg::OP_NONE;
        end else begin
            last_op <= op;
            if (new_op) begin
                if (op == gcu_bus_pkg::OP_WRITE_RAM) begin
                    state <= ST_WRITE;
                end else if (start_read) begin
                    state <= ST_READ_ADDR;
                end else begin
                    state <= ST_IDLE;
                end
            end else begin
                case (state)
                    ST_WRITE:     state <= ST_WRITE_DONE;
                    ST_READ_ADDR: state <= ST_READ_WAIT;
                    ST_READ_WAIT: state <= ST_READ_DONE;
                    default:      state <= state;
                endcase
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (new_op && op == gcu_bus_pkg::OP_WRITE_RAM) begin
            ram_addr  <= ptr;
            ram_wdata <= din;
        end else if (start_read) begin
            // low word sits one past the pointer
            ram_addr <= ptr + AW'(op == gcu_bus_pkg::OP_READ_L);
        end
        if (!new_op && state == ST_READ_WAIT) begin
            dout <= ram_rdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/gcu_video_status.sv
// ------------------------------------------------------------
// sync and blank decode from the beam counters, plus the
// vertical interrupt line
// ------------------------------------------------------------
`default_nettype none

module gcu_video_status (
    input  wire logic                              RESET96,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]   h,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]   v,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]   hs_start,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]   hs_end,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]   vs_start,
    input  wire logic [gcu_vram_pkg::BEAM_W-1:0]   vs_end,
    input  wire logic [gcu_bus_pkg::REG_NUM_W-1:0] sel_reg,
    output logic                                   hsync,
    output logic                                   vsync,
    output logic                                   fblank,
    output logic                                   vint
);

    logic vint_masked;

    // horizontal limits are exclusive, vertical inclusive
    assign hsync  = !(h > hs_start && h < hs_end);
    assign vsync  = !(v >= vs_start && v <= vs_end);
    assign fblank = hsync && vsync;

    assign vint_masked = (sel_reg == gcu_bus_pkg::VINT_MASK_REG0)
                      || (sel_reg == gcu_bus_pkg::VINT_MASK_REG1)
                      || (sel_reg == gcu_bus_pkg::VINT_MASK_REG2);

    // active low, also held low through reset
    assign vint = !(v == gcu_vram_pkg::VINT_LINE || vint_masked || RESET96);

endmodule

`default_nettype wire

//--- logic/gcu_vram.sv
// ------------------------------------------------------------
// main video RAM with the per-layer copies that feed
// the renderer read ports
// ------------------------------------------------------------
`default_nettype none

module gcu_vram #(
    parameter int AW       = gcu_vram_pkg::VRAM_AW,
    parameter int LAYER_AW = gcu_vram_pkg::LAYER_AW
) (
    input  wire logic                           CLK96,
    input  wire logic [AW-1:0]                  ram_addr,
    input  wire logic [gcu_bus_pkg::DATA_W-1:0] ram_wdata,
    input  wire logic                           ram_we,
    input  wire logic [LAYER_AW-1:0]            scr0_addr,
    input  wire logic [LAYER_AW-1:0]            scr1_addr,
    input  wire logic [LAYER_AW-1:0]            scr2_addr,
    input  wire logic [LAYER_AW-1:0]            spr_addr,
    output logic      [gcu_bus_pkg::DATA_W-1:0] ram_rdata,
    output logic      [gcu_bus_pkg::DATA_W-1:0] scr0_dout,
    output logic      [gcu_bus_pkg::DATA_W-1:0] scr1_dout,
    output logic      [gcu_bus_pkg::DATA_W-1:0] scr2_dout,
    output logic      [gcu_bus_pkg::DATA_W-1:0] spr_dout
);

    // region i spans [lo[i], hi[i])
    localparam logic [AW-1:0] REGION_LO [4] = '{
        AW'(gcu_vram_pkg::SCR0_BASE), AW'(gcu_vram_pkg::SCR1_BASE),
        AW'(gcu_vram_pkg::SCR2_BASE), AW'(gcu_vram_pkg::SPR_BASE)
    };
    localparam logic [AW-1:0] REGION_HI [4] = '{
        AW'(gcu_vram_pkg::SCR1_BASE), AW'(gcu_vram_pkg::SCR2_BASE),
        AW'(gcu_vram_pkg::SPR_BASE), AW'(gcu_vram_pkg::SPR_END)
    };

    logic [gcu_bus_pkg::DATA_W-1:0] main_mem  [2**AW];
    logic [gcu_bus_pkg::DATA_W-1:0] layer_mem [4][2**LAYER_AW];
    logic [gcu_bus_pkg::DATA_W-1:0] layer_q   [4];
    logic [LAYER_AW-1:0]            layer_addr [4];
    logic [3:0]                     layer_we;

    assign layer_addr = '{scr0_addr, scr1_addr, scr2_addr, spr_addr};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            layer_we[i] = ram_we && ram_addr >= REGION_LO[i] && ram_addr < REGION_HI[i];
        end
    end

    always_ff @(posedge CLK96) begin
        if (ram_we) begin
            main_mem[ram_addr] <= ram_wdata;
        end
        ram_rdata <= main_mem[ram_addr];
    end

    always_ff @(posedge CLK96) begin
        for (int i = 0; i < 4; i++) begin
            if (layer_we[i]) begin
                layer_mem[i][ram_addr[LAYER_AW-1:0]] <= ram_wdata;
            end
            layer_q[i] <= layer_mem[i][layer_addr[i]];
        end
    end

    assign scr0_dout = layer_q[0];
    assign scr1_dout = layer_q[1];
    assign scr2_dout = layer_q[2];
    assign spr_dout  = layer_q[3];

endmodule

`default_nettype wire

//--- logic/gcu_scroll_regs.sv
// ------------------------------------------------------------
// register select latch and the eight layer scroll registers
// ------------------------------------------------------------
`default_nettype none

module gcu_scroll_regs (
    input  wire logic                              CLK96,
    input  wire logic                              RESET96,
    input  wire logic                              reg_select,
    input  wire logic                              reg_write,
    input  wire logic [gcu_bus_pkg::DATA_W-1:0]    din,
    output logic      [gcu_bus_pkg::REG_NUM_W-1:0] sel_reg,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0]  bg_scroll_x,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0]  bg_scroll_y,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0]  fg_scroll_x,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0]  fg_scroll_y,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0]  txt_scroll_x,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0]  txt_scroll_y,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0]  spr_scroll_x,
    output logic      [gcu_bus_pkg::SCROLL_W-1:0]  spr_scroll_y
);

    logic [gcu_bus_pkg::SCROLL_W-1:0] scroll [8];
    logic                             scroll_hit;

    // bit 7 is ignored, so 0x80-0x87 alias 0x00-0x07
    assign scroll_hit = (sel_reg[6:3] == 4'h0);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sel_reg <= '1;
        end else if (reg_select) begin
            sel_reg <= din[gcu_bus_pkg::REG_NUM_W-1:0] & gcu_bus_pkg::REG_SEL_MASK;
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            for (int i = 0; i < 8; i++) begin
                scroll[i] <= '0;
            end
        end else if (reg_write && scroll_hit) begin
            scroll[sel_reg[2:0]] <= din[gcu_bus_pkg::SCROLL_W-1:0];
        end
    end

    // even numbers are x, odd are y
    assign bg_scroll_x  = scroll[0];
    assign bg_scroll_y  = scroll[1];
    assign fg_scroll_x  = scroll[2];
    assign fg_scroll_y  = scroll[3];
    assign txt_scroll_x = scroll[4];
    assign txt_scroll_y = scroll[5];
    assign spr_scroll_x = scroll[6];
    assign spr_scroll_y = scroll[7];

endmodule

`default_nettype wire

//--- logic/gcu_ram_pointer.sv
// ------------------------------------------------------------
// video RAM pointer, loaded by the CPU and stepped after
// every RAM write
// ------------------------------------------------------------
`default_nettype none

module gcu_ram_pointer #(
    parameter int AW = gcu_vram_pkg::VRAM_AW
) (
    input  wire logic                           CLK96,
    input  wire logic                           RESET96,
    input  wire logic                           ptr_load,
    input  wire logic                           ptr_inc,
    input  wire logic [gcu_bus_pkg::DATA_W-1:0] din,
    output logic      [AW-1:0]                  ptr
);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            ptr <= '0;
        end else if (ptr_load) begin
            // upper din bits fall outside the RAM
            ptr <= din[AW-1:0];
        end else if (ptr_inc) begin
            ptr <= ptr + AW'(1);
        end
    end

endmodule

`default_nettype wire

//--- logic/gcu_vram_pkg.sv
// ------------------------------------------------------------
// video RAM layout for the graphics control unit:
// address widths, layer region bases, beam counter width
// ------------------------------------------------------------
`default_nettype none

package gcu_vram_pkg;

    localparam int VRAM_AW  = 13;
    localparam int LAYER_AW = 11;

    // each layer owns a 2K-word window of the main RAM
    localparam logic [VRAM_AW-1:0] SCR0_BASE = 13'h0000;
    localparam logic [VRAM_AW-1:0] SCR1_BASE = 13'h0800;
    localparam logic [VRAM_AW-1:0] SCR2_BASE = 13'h1000;
    localparam logic [VRAM_AW-1:0] SPR_BASE  = 13'h1800;
    // sprite window is only 1K words
    localparam logic [VRAM_AW-1:0] SPR_END   = 13'h1C00;

    localparam int BEAM_W = 9;

    localparam logic [BEAM_W-1:0] VINT_LINE = 9'h0E6;

endpackage

`default_nettype wire

//--- logic/gcu_bus_pkg.sv
// ------------------------------------------------------------
// CPU bus definitions for the graphics control unit:
// data width, bus op kinds, register numbers and masks
// ------------------------------------------------------------
`default_nettype none

package gcu_bus_pkg;

    localparam int DATA_W    = 16;
    localparam int REG_NUM_W = 8;
    localparam int SCROLL_W  = 13;

    // ops in the priority order the strobes are decoded
    typedef enum logic [2:0] {
        OP_NONE,
        OP_SELECT,
        OP_WRITE_REG,
        OP_SET_PTR,
        OP_WRITE_RAM,
        OP_READ_H,
        OP_READ_L
    } bus_op_t;

    localparam logic [REG_NUM_W-1:0] REG_SEL_MASK = 8'h8F;

    // selecting any of these holds vint low
    localparam logic [REG_NUM_W-1:0] VINT_MASK_REG0 = 8'h0F;
    localparam logic [REG_NUM_W-1:0] VINT_MASK_REG1 = 8'h8F;
    localparam logic [REG_NUM_W-1:0] VINT_MASK_REG2 = 8'h0E;

endpackage

`default_nettype wire
